// File: source/tcm_pkg.sv
/*
 * Shared geometry and type definitions for the tightly coupled memory.
 * Byte addresses are TCM_AW bits wide and cover TCM_DEPTH 32-bit words.
 */
`default_nettype none

package tcm_pkg;

    // ========================================
    // Memory geometry
    // ========================================
    localparam int TCM_DEPTH = 256;    // Words in the SRAM
    localparam int TCM_AW    = 10;     // Byte address width
    localparam int TCM_WAW   = 8;      // Word index width
    localparam int TCM_DW    = 32;     // Data width
    localparam int TCM_MW    = 4;      // One mask bit per byte lane

    // ========================================
    // Types
    // ========================================
    typedef enum logic [2:0] {
        LSU_LB  = 3'd0,    // Signed byte load
        LSU_LH  = 3'd1,    // Signed halfword load
        LSU_LW  = 3'd2,
        LSU_LBU = 3'd3,    // Unsigned byte load
        LSU_LHU = 3'd4,    // Unsigned halfword load
        LSU_SB  = 3'd5,
        LSU_SH  = 3'd6,
        LSU_SW  = 3'd7
    } lsu_op_e;

    typedef enum logic {
        OWNER_FETCH = 1'b0,
        OWNER_LSU   = 1'b1
    } arb_owner_e;

    typedef enum logic [1:0] {L_IDLE, L_REQ, L_WAIT} lsu_state_e;           // Load/store FSM

    typedef enum logic [1:0] {F_IDLE, F_REQ, F_WAIT, F_HOLD} fetch_state_e; // Fetch FSM

endpackage

`default_nettype wire

// File: source/tcm_sram.sv
/*
 * Single-port SRAM, one write or one read per cycle.
 * Read data is valid one cycle after the address. No reset, no preload,
 * so unwritten words read as X.
 */
`timescale 1ns/1ps
`default_nettype none

module tcm_sram (
    input  wire                          clk,
    input  wire  [tcm_pkg::TCM_WAW-1:0]  addr,    // Word index
    input  wire  [tcm_pkg::TCM_DW-1:0]   din,
    input  wire                          we,
    input  wire  [tcm_pkg::TCM_MW-1:0]   wem,     // Byte lane enables
    output logic [tcm_pkg::TCM_DW-1:0]   dout
);

    import tcm_pkg::*;

    // ========================================
    // Storage
    // ========================================
    logic [TCM_DW-1:0]  mem [0:TCM_DEPTH-1];
    logic [TCM_WAW-1:0] addr_r;                  // Registered read address

    // Byte lane writes
    always_ff @(posedge clk) begin
        for (int i = 0; i < TCM_MW; i++) begin
            if (we && wem[i]) begin
                mem[addr][8*i +: 8] <= din[8*i +: 8];   // Only enabled lanes change
            end
        end
    end

    // Address captured on reads only
    always_ff @(posedge clk) begin
        if (!we) begin
            addr_r <= addr;                      // Held across writes
        end
    end

    // Output follows registered address, steady while writing
    assign dout = mem[addr_r];

    // ========================================
    // Checks
    // ========================================
    // A write with an empty mask means the requester built a bad lane mask
    a_wem_nonzero: assert property (@(posedge clk) we |-> (wem != '0))
        else $error("SRAM write with empty byte mask");

endmodule

`default_nettype wire

// File: source/tcm_arbiter.sv
/*
 * Round-robin arbiter between fetch and load/store requesters.
 * Each requester may have one request outstanding. Responses have no
 * back-pressure and arrive exactly one cycle after the grant.
 */
`timescale 1ns/1ps
`default_nettype none

module tcm_arbiter (
    input  wire                         clk,
    input  wire                         rst_n,
    // Fetch requester
    input  wire                         f_req_valid,
    output logic                        f_req_ready,
    input  wire  [tcm_pkg::TCM_AW-1:0]  f_addr,
    // Load/store requester
    input  wire                         l_req_valid,
    output logic                        l_req_ready,
    input  wire  [tcm_pkg::TCM_AW-1:0]  l_addr,
    input  wire                         l_we,
    input  wire  [tcm_pkg::TCM_MW-1:0]  l_wmask,
    input  wire  [tcm_pkg::TCM_DW-1:0]  l_wdata,
    // Responses
    output logic                        f_rsp_valid,
    output logic                        l_rsp_valid,
    output logic [tcm_pkg::TCM_DW-1:0]  rsp_data
);

    import tcm_pkg::*;

    arb_owner_e         last_owner;     // Port granted most recently
    logic               rsp_pend;       // Grant issued on the last edge
    logic               grant_f;
    logic               grant_l;
    logic [TCM_WAW-1:0] sram_addr;
    logic               sram_we;

    // ========================================
    // Arbitration
    // ========================================
    // Ready never looks at the own valid, only the other port and history
    assign f_req_ready = !l_req_valid || (last_owner == OWNER_LSU);
    assign l_req_ready = !f_req_valid || (last_owner == OWNER_FETCH);

    assign grant_f = f_req_valid && f_req_ready;
    assign grant_l = l_req_valid && l_req_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            last_owner <= OWNER_LSU;    // Fetch wins the first tie
            rsp_pend   <= 1'b0;
        end else begin
            rsp_pend <= grant_f || grant_l;
            if (grant_f || grant_l) begin
                last_owner <= grant_l ? OWNER_LSU : OWNER_FETCH;   // Also tags the response
            end
        end
    end

    // ========================================
    // SRAM side
    // ========================================
    assign sram_addr = grant_l ? l_addr[TCM_AW-1:2] : f_addr[TCM_AW-1:2];   // Word index
    assign sram_we   = grant_l && l_we;

    tcm_sram u_sram (
        .clk  (clk),
        .addr (sram_addr),
        .din  (l_wdata),
        .we   (sram_we),
        .wem  (l_wmask),
        .dout (rsp_data)
    );

    // Response goes to whoever owned the previous edge
    assign f_rsp_valid = rsp_pend && (last_owner == OWNER_FETCH);
    assign l_rsp_valid = rsp_pend && (last_owner == OWNER_LSU);   // Store ack too

    // ========================================
    // Checks
    // ========================================
    a_one_grant: assert property (@(posedge clk) disable iff (!rst_n)
        !(grant_f && grant_l))
        else $error("Both ports granted in one cycle");

    a_rsp_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({f_rsp_valid, l_rsp_valid}))
        else $error("Response valids not one-hot");

endmodule

`default_nettype wire

// File: source/lsu_port.sv
/*
 * Load/store port, one operation in flight at a time.
 * Accesses must be naturally aligned. Stores also return ld_valid,
 * with ld_data zero.
 */
`timescale 1ns/1ps
`default_nettype none

module lsu_port (
    input  wire                         clk,
    input  wire                         rst_n,
    // Operation input
    input  wire                         op_valid,
    output logic                        op_ready,
    input  wire  tcm_pkg::lsu_op_e      op,
    input  wire  [tcm_pkg::TCM_AW-1:0]  op_addr,
    input  wire  [tcm_pkg::TCM_DW-1:0]  op_wdata,
    // Result
    output logic                        ld_valid,
    output logic [tcm_pkg::TCM_DW-1:0]  ld_data,
    // Arbiter side
    output logic                        l_req_valid,
    input  wire                         l_req_ready,
    output logic [tcm_pkg::TCM_AW-1:0]  l_addr,
    output logic                        l_we,
    output logic [tcm_pkg::TCM_MW-1:0]  l_wmask,
    output logic [tcm_pkg::TCM_DW-1:0]  l_wdata,
    input  wire                         l_rsp_valid,
    input  wire  [tcm_pkg::TCM_DW-1:0]  rsp_data
);

    import tcm_pkg::*;

    lsu_state_e        state;
    lsu_op_e           op_q;            // Latched opcode
    logic [TCM_AW-1:0] addr_q;          // Latched byte address
    logic [TCM_DW-1:0] wdata_q;
    logic [TCM_DW-1:0] lane;            // Addressed bytes moved to bit 0
    logic [TCM_DW-1:0] load_ext;

    // ========================================
    // Control
    // ========================================
    assign op_ready    = (state == L_IDLE);
    assign l_req_valid = (state == L_REQ);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= L_IDLE;
            ld_valid <= 1'b0;
        end else begin
            ld_valid <= 1'b0;           // Single cycle pulse
            case (state)
                L_IDLE: if (op_valid) state <= L_REQ;
                L_REQ:  if (l_req_ready) state <= L_WAIT;
                L_WAIT: begin
                    if (l_rsp_valid) begin
                        ld_valid <= 1'b1;
                        state    <= L_IDLE;
                    end
                end
                default: state <= L_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (op_valid && op_ready) begin
            op_q    <= op;
            addr_q  <= op_addr;
            wdata_q <= op_wdata;
        end
        if (state == L_WAIT && l_rsp_valid) begin
            ld_data <= load_ext;
        end
    end

    // ========================================
    // Store lanes
    // ========================================
    assign l_addr = addr_q;
    assign l_we   = op_q inside {LSU_SB, LSU_SH, LSU_SW};

    always_comb begin
        case (op_q)
            LSU_SB: begin
                l_wmask = 4'b0001 << addr_q[1:0];
                l_wdata = {4{wdata_q[7:0]}};      // Byte on every lane
            end
            LSU_SH: begin
                l_wmask = addr_q[1] ? 4'b1100 : 4'b0011;
                l_wdata = {2{wdata_q[15:0]}};
            end
            LSU_SW: begin
                l_wmask = 4'b1111;
                l_wdata = wdata_q;
            end
            default: begin                       // Loads write nothing
                l_wmask = 4'b0000;
                l_wdata = wdata_q;
            end
        endcase
    end

    // ========================================
    // Load extraction
    // ========================================
    assign lane = rsp_data >> {addr_q[1:0], 3'b000};

    always_comb begin
        case (op_q)
            LSU_LB:  load_ext = {{24{lane[7]}}, lane[7:0]};
            LSU_LBU: load_ext = {24'd0, lane[7:0]};
            LSU_LH:  load_ext = {{16{lane[15]}}, lane[15:0]};
            LSU_LHU: load_ext = {16'd0, lane[15:0]};
            LSU_LW:  load_ext = rsp_data;
            default: load_ext = '0;              // Stores report zero
        endcase
    end

    // Misaligned accesses are outside the supported range
    a_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        (op_valid && op_ready) |->
            (!(op inside {LSU_LH, LSU_LHU, LSU_SH}) || !op_addr[0]) &&
            (!(op inside {LSU_LW, LSU_SW}) || (op_addr[1:0] == 2'b00)))
        else $error("Misaligned load/store at %h", op_addr);

endmodule

`default_nettype wire

// File: source/fetch_port.sv
/*
 * Sequential instruction fetch, one word at a time.
 * Idle until the first redirect. A redirect during an outstanding
 * fetch lets that fetch finish and drops its response.
 */
`timescale 1ns/1ps
`default_nettype none

module fetch_port (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         redirect_valid,
    input  wire  [tcm_pkg::TCM_AW-1:0]  redirect_pc,
    // Instruction output
    output logic                        instr_valid,
    input  wire                         instr_ready,
    output logic [tcm_pkg::TCM_AW-1:0]  instr_pc,
    output logic [tcm_pkg::TCM_DW-1:0]  instr_data,
    // Arbiter side
    output logic                        f_req_valid,
    input  wire                         f_req_ready,
    output logic [tcm_pkg::TCM_AW-1:0]  f_addr,
    input  wire                         f_rsp_valid,
    input  wire  [tcm_pkg::TCM_DW-1:0]  rsp_data
);

    import tcm_pkg::*;

    fetch_state_e      state;
    logic [TCM_AW-1:0] pc;              // Address of current fetch
    logic [TCM_AW-1:0] redir_pc;        // Deferred redirect target
    logic              stale;           // Outstanding fetch to be dropped
    logic              rsp_in;
    logic              redir_now;
    logic              redir_late;

    assign rsp_in     = (state == F_WAIT) && f_rsp_valid;
    // Redirect applies at once when nothing is mid-request
    assign redir_now  = redirect_valid && (state == F_IDLE || state == F_HOLD || rsp_in);
    assign redir_late = redirect_valid && !redir_now;   // REQ or WAIT

    assign f_req_valid = (state == F_REQ);
    assign f_addr      = pc;
    assign instr_valid = (state == F_HOLD);
    assign instr_pc    = pc;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= F_IDLE;
            stale <= 1'b0;
        end else if (redir_now) begin
            state <= F_REQ;
            stale <= 1'b0;
        end else begin
            if (redir_late) stale <= 1'b1;
            case (state)
                F_REQ:  if (f_req_ready) state <= F_WAIT;
                F_WAIT: begin
                    if (f_rsp_valid) begin
                        state <= stale ? F_REQ : F_HOLD;
                        stale <= 1'b0;          // Dropped response consumed
                    end
                end
                F_HOLD: if (instr_ready) state <= F_REQ;
                default: ;                      // Idle until redirect
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (redir_now) pc <= redirect_pc;
        else if (rsp_in && stale) pc <= redir_pc;                    // Restart at target
        else if (state == F_HOLD && instr_ready) pc <= pc + TCM_AW'(4);
        if (redir_late) redir_pc <= redirect_pc;
        if (rsp_in && !stale) instr_data <= rsp_data;
    end

    // Request payload stays put until accepted
    a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (f_req_valid && !f_req_ready) |=> (f_req_valid && $stable(f_addr)))
        else $error("Fetch request dropped or changed before ready");

endmodule

`default_nettype wire

// File: source/tcm_top.sv
/*
 * TCM subsystem top, fetch and load/store ports sharing one SRAM.
 * No misaligned accesses, no bus errors, no preloaded contents.
 */
`timescale 1ns/1ps
`default_nettype none

module tcm_top (
    input  wire                         clk,
    input  wire                         rst_n,
    // Fetch side
    input  wire                         redirect_valid,
    input  wire  [tcm_pkg::TCM_AW-1:0]  redirect_pc,
    output logic                        instr_valid,
    input  wire                         instr_ready,
    output logic [tcm_pkg::TCM_AW-1:0]  instr_pc,
    output logic [tcm_pkg::TCM_DW-1:0]  instr_data,
    // Load/store side
    input  wire                         op_valid,
    output logic                        op_ready,
    input  wire  tcm_pkg::lsu_op_e      op,
    input  wire  [tcm_pkg::TCM_AW-1:0]  op_addr,
    input  wire  [tcm_pkg::TCM_DW-1:0]  op_wdata,
    output logic                        ld_valid,
    output logic [tcm_pkg::TCM_DW-1:0]  ld_data
);

    import tcm_pkg::*;

    // ========================================
    // Port to arbiter wiring
    // ========================================
    logic              f_req_valid;
    logic              f_req_ready;
    logic [TCM_AW-1:0] f_addr;
    logic              f_rsp_valid;
    logic              l_req_valid;
    logic              l_req_ready;
    logic [TCM_AW-1:0] l_addr;
    logic              l_we;
    logic [TCM_MW-1:0] l_wmask;
    logic [TCM_DW-1:0] l_wdata;
    logic              l_rsp_valid;
    logic [TCM_DW-1:0] rsp_data;        // Shared by both ports

    fetch_port u_fetch (
        .clk(clk), .rst_n(rst_n),
        .redirect_valid(redirect_valid), .redirect_pc(redirect_pc),
        .instr_valid(instr_valid), .instr_ready(instr_ready),
        .instr_pc(instr_pc), .instr_data(instr_data),
        .f_req_valid(f_req_valid), .f_req_ready(f_req_ready), .f_addr(f_addr),
        .f_rsp_valid(f_rsp_valid), .rsp_data(rsp_data)
    );

    lsu_port u_lsu (
        .clk(clk), .rst_n(rst_n),
        .op_valid(op_valid), .op_ready(op_ready), .op(op),
        .op_addr(op_addr), .op_wdata(op_wdata),
        .ld_valid(ld_valid), .ld_data(ld_data),
        .l_req_valid(l_req_valid), .l_req_ready(l_req_ready), .l_addr(l_addr),
        .l_we(l_we), .l_wmask(l_wmask), .l_wdata(l_wdata),
        .l_rsp_valid(l_rsp_valid), .rsp_data(rsp_data)
    );

    tcm_arbiter u_arb (
        .clk(clk), .rst_n(rst_n),
        .f_req_valid(f_req_valid), .f_req_ready(f_req_ready), .f_addr(f_addr),
        .l_req_valid(l_req_valid), .l_req_ready(l_req_ready), .l_addr(l_addr),
        .l_we(l_we), .l_wmask(l_wmask), .l_wdata(l_wdata),
        .f_rsp_valid(f_rsp_valid), .l_rsp_valid(l_rsp_valid),
        .rsp_data(rsp_data)
    );

endmodule

`default_nettype wire

// File: test/tcm_tb.sv
/*
 * Self-checking testbench for the TCM subsystem.
 * The whole SRAM is filled by word stores first, so every later read hits
 * written data. Stores that run beside fetching stay in the upper half.
 */
`timescale 1ns/1ps
`default_nettype none

module tcm_tb;

    import tcm_pkg::*;

    localparam int OP_TIMEOUT    = 60;       // Cycles per load/store wait
    localparam int INSTR_TIMEOUT = 200;      // Cycles without a new instruction

    logic              clk;
    logic              rst_n;
    logic              redirect_valid;
    logic [TCM_AW-1:0] redirect_pc;
    logic              instr_valid;
    logic              instr_ready;
    logic [TCM_AW-1:0] instr_pc;
    logic [TCM_DW-1:0] instr_data;
    logic              op_valid;
    logic              op_ready;
    lsu_op_e           op;
    logic [TCM_AW-1:0] op_addr;
    logic [TCM_DW-1:0] op_wdata;
    logic              ld_valid;
    logic [TCM_DW-1:0] ld_data;

    logic [7:0]        ref_mem [0:TCM_DEPTH*4-1];   // Byte view of the SRAM
    lsu_op_e           exp_op_q [$];                // Outstanding ops, oldest first
    logic [TCM_AW-1:0] exp_addr_q [$];
    logic [TCM_DW-1:0] exp_data_q [$];
    lsu_op_e           mon_op;
    logic [TCM_AW-1:0] mon_addr;
    logic [TCM_DW-1:0] mon_exp;
    int                ld_count;                    // ld_valid pulses seen
    int                instr_taken;                 // Instructions accepted
    logic [TCM_AW-1:0] next_pc;                     // Expected next instr_pc

    tcm_top dut (
        .clk(clk), .rst_n(rst_n),
        .redirect_valid(redirect_valid), .redirect_pc(redirect_pc),
        .instr_valid(instr_valid), .instr_ready(instr_ready),
        .instr_pc(instr_pc), .instr_data(instr_data),
        .op_valid(op_valid), .op_ready(op_ready), .op(op),
        .op_addr(op_addr), .op_wdata(op_wdata),
        .ld_valid(ld_valid), .ld_data(ld_data)
    );

    always #50 clk = ~clk;                          // 100 ns period

    // ========================================
    // Reference model
    // ========================================
    function automatic logic [TCM_DW-1:0] ref_load(input lsu_op_e kind,
                                                   input logic [TCM_AW-1:0] addr);
        int                a;
        int                w;
        logic [TCM_DW-1:0] word;
        logic [15:0]       half;
        logic [7:0]        byte_v;
        a      = int'(addr);
        w      = a & ~3;                            // Word base
        word   = {ref_mem[w+3], ref_mem[w+2], ref_mem[w+1], ref_mem[w]};
        half   = {ref_mem[a | 1], ref_mem[a & ~1]};
        byte_v = ref_mem[a];
        case (kind)
            LSU_LB:  return {{24{byte_v[7]}}, byte_v};
            LSU_LBU: return {24'd0, byte_v};
            LSU_LH:  return {{16{half[15]}}, half};
            LSU_LHU: return {16'd0, half};
            LSU_LW:  return word;
            default: return '0;                     // Stores report zero
        endcase
    endfunction

    task automatic ref_store(input lsu_op_e kind, input logic [TCM_AW-1:0] addr,
                             input logic [TCM_DW-1:0] data);
        int a;
        a = int'(addr);
        case (kind)
            LSU_SB: ref_mem[a] = data[7:0];
            LSU_SH: begin
                ref_mem[a]   = data[7:0];
                ref_mem[a+1] = data[15:8];
            end
            LSU_SW: begin
                for (int i = 0; i < 4; i++) begin
                    ref_mem[a+i] = data[8*i +: 8];   // Little endian
                end
            end
            default: ;
        endcase
    endtask

    function automatic logic [TCM_AW-1:0] align_for(input lsu_op_e kind,
                                                    input logic [TCM_AW-1:0] raw);
        case (kind)
            LSU_LH, LSU_LHU, LSU_SH: return {raw[TCM_AW-1:1], 1'b0};
            LSU_LW, LSU_SW:          return {raw[TCM_AW-1:2], 2'b00};
            default:                 return raw;
        endcase
    endfunction

    // Odd multiplier keeps every word index distinct
    function automatic logic [TCM_DW-1:0] fill_word(input int idx);
        return 32'((idx + 1) * 32'h9e37_79b1) ^ 32'h5a5a_0000;
    endfunction

    // ========================================
    // Checks
    // ========================================
    task automatic abort_run();
        $display("*** TEST FAILED ***");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_load(input lsu_op_e kind, input logic [TCM_AW-1:0] addr,
                              input logic [TCM_DW-1:0] got, input logic [TCM_DW-1:0] exp);
        if (got !== exp) begin
            $display("FAILED t=%0t ld_data (%s @ %h) got %h expected %h",
                     $time, kind.name(), addr, got, exp);
            abort_run();
        end
    endtask

    task automatic check_instr(input logic [TCM_AW-1:0] got_pc, input logic [TCM_DW-1:0] got_data,
                               input logic [TCM_AW-1:0] exp_pc, input logic [TCM_DW-1:0] exp_data);
        if (got_pc !== exp_pc) begin
            $display("FAILED t=%0t instr_pc got %h expected %h", $time, got_pc, exp_pc);
            abort_run();
        end
        if (got_data !== exp_data) begin
            $display("FAILED t=%0t instr_data (pc %h) got %h expected %h",
                     $time, exp_pc, got_data, exp_data);
            abort_run();
        end
    endtask

    // Compares every load/store result in issue order
    always @(negedge clk) begin
        if (rst_n && ld_valid) begin
            if (exp_op_q.size() == 0) begin
                $display("ld_valid pulsed with no operation outstanding at %0t", $time);
                abort_run();
            end else begin
                mon_op   = exp_op_q.pop_front();
                mon_addr = exp_addr_q.pop_front();
                mon_exp  = exp_data_q.pop_front();
                check_load(mon_op, mon_addr, ld_data, mon_exp);
                ld_count++;
            end
        end
    end

    // ========================================
    // Stimulus tasks
    // ========================================
    task automatic do_op(input lsu_op_e kind, input logic [TCM_AW-1:0] addr,
                         input logic [TCM_DW-1:0] wdata);
        int tmo;
        int target;
        tmo = 0;
        @(negedge clk);
        while (!op_ready) begin
            tmo++;
            if (tmo > OP_TIMEOUT) begin
                $display("op_ready stayed low, load/store port never freed");
                abort_run();
            end
            @(negedge clk);
        end
        op_valid = 1'b1;                            // Accepted on the next posedge
        op       = kind;
        op_addr  = addr;
        op_wdata = wdata;
        ref_store(kind, addr, wdata);
        exp_op_q.push_back(kind);
        exp_addr_q.push_back(addr);
        exp_data_q.push_back(ref_load(kind, addr));
        target = ld_count + 1;
        @(negedge clk);
        op_valid = 1'b0;
        tmo = 0;
        while (ld_count < target) begin              // Monitor counts on negedge
            tmo++;
            if (tmo > OP_TIMEOUT) begin
                $display("No ld_valid for %s at %h", kind.name(), addr);
                abort_run();
            end
            @(posedge clk);
        end
    endtask

    // Set at the current negedge, drop one cycle later
    task automatic pulse_redirect(input logic [TCM_AW-1:0] pc);
        redirect_valid = 1'b1;
        redirect_pc    = pc;
        next_pc        = pc;
        @(negedge clk);
        redirect_valid = 1'b0;
    endtask

    task automatic take_instrs(input int count, input int ready_pct);
        int                taken;
        int                idle;
        logic              held;
        logic              rdy;
        logic [TCM_AW-1:0] held_pc;
        logic [TCM_DW-1:0] held_data;
        taken = 0;
        idle  = 0;
        held  = 1'b0;
        while (taken < count) begin
            @(negedge clk);
            if (held) begin                         // Stalled on the last edge
                if (!instr_valid) begin
                    $display("instr_valid dropped without instr_ready at %0t", $time);
                    abort_run();
                end
                check_instr(instr_pc, instr_data, held_pc, held_data);
            end
            rdy         = (($urandom % 100) < ready_pct);
            instr_ready = rdy;
            held        = instr_valid && !rdy;
            held_pc     = instr_pc;
            held_data   = instr_data;
            if (instr_valid && rdy) begin           // Transfer on next posedge
                check_instr(instr_pc, instr_data, next_pc, ref_load(LSU_LW, next_pc));
                next_pc = next_pc + TCM_AW'(4);
                taken++;
                instr_taken++;
                idle = 0;
            end else begin
                idle++;
                if (idle > INSTR_TIMEOUT) begin
                    $display("Fetch port delivered no instruction for %0d cycles", idle);
                    abort_run();
                end
            end
        end
        @(negedge clk);
        instr_ready = 1'b0;                         // Park fetch in HOLD
    endtask

    // ========================================
    // Test sequence
    // ========================================
    initial begin
        lsu_op_e           kind;
        logic [TCM_AW-1:0] addr;
        int                instrs_at_lsu_end;
        int                lds_at_fetch_end;
        int                ld_base;
        clk            = 1'b0;
        rst_n          = 1'b0;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        instr_ready    = 1'b0;
        op_valid       = 1'b0;
        op             = LSU_LW;
        op_addr        = '0;
        op_wdata       = '0;
        ld_count       = 0;
        instr_taken    = 0;
        next_pc        = '0;
        void'($urandom(32'hee71));
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        if (instr_valid !== 1'b0 || ld_valid !== 1'b0 || op_ready !== 1'b1) begin
            $display("Outputs not idle after reset");
            abort_run();
        end

        // Word fill and read back
        for (int i = 0; i < TCM_DEPTH; i++) begin
            do_op(LSU_SW, TCM_AW'(i * 4), fill_word(i));
        end
        for (int i = 0; i < TCM_DEPTH; i++) begin
            do_op(LSU_LW, TCM_AW'(i * 4), '0);
        end

        // Sub-word stores, then every load flavour
        for (int n = 0; n < 48; n++) begin
            kind = (($urandom % 2) == 0) ? LSU_SB : LSU_SH;
            do_op(kind, align_for(kind, TCM_AW'($urandom)), $urandom);
        end
        for (int n = 0; n < 64; n++) begin
            kind = lsu_op_e'(3'($urandom % 5));     // LB, LH, LW, LBU, LHU
            do_op(kind, align_for(kind, TCM_AW'($urandom)), '0);
        end

        // Sequential fetch, then with back-pressure
        @(negedge clk);
        pulse_redirect('0);
        take_instrs(16, 100);
        take_instrs(24, 40);

        // Loads and stores beside continuous fetching
        ld_base = ld_count;
        fork
            begin
                for (int n = 0; n < 40; n++) begin
                    kind = lsu_op_e'(3'($urandom));
                    addr = align_for(kind, TCM_AW'($urandom));
                    if (kind inside {LSU_SB, LSU_SH, LSU_SW}) begin
                        addr[TCM_AW-1] = 1'b1;      // Away from fetched code
                    end
                    do_op(kind, addr, $urandom);
                end
                instrs_at_lsu_end = instr_taken;
            end
            begin
                take_instrs(64, 80);
                @(posedge clk);
                lds_at_fetch_end = ld_count - ld_base;
            end
        join
        if (instrs_at_lsu_end < 48 || lds_at_fetch_end < 8) begin
            $display("One port starved, fetch %0d instrs, lsu %0d ops",
                     instrs_at_lsu_end, lds_at_fetch_end);
            abort_run();
        end

        // Second redirect lands in REQ, then WAIT, then HOLD
        for (int gap = 0; gap < 3; gap++) begin
            @(negedge clk);
            pulse_redirect(TCM_AW'(10'h040));
            repeat (gap) @(negedge clk);
            pulse_redirect(TCM_AW'(10'h100 + gap * 16));
            take_instrs(4, 100);
        end

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
source/tcm_pkg.sv
source/tcm_sram.sv
source/tcm_arbiter.sv
source/lsu_port.sv
source/fetch_port.sv
source/tcm_top.sv
test/tcm_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the TCM testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module tcm_tb -o tcm_sim

status=0
out=$(./obj_dir/tcm_sim) || status=$?
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qF '*** TEST PASSED ***'; then
    exit 0
fi
echo "Simulation did not pass, exit status $status"
exit 1
